/* src/mem_slot_pkg.sv */
/*
 * Memory slot package
 * Width types, access size codes, controller states and line geometry
 * shared by the load/store memory slot
 */
package mem_slot_pkg;

	// ==============================
	// Widths
	// ==============================

	// Byte address of an access
	typedef logic [15:0] addr_t;

	// One bus line, also the widest operand
	typedef logic [63:0] line_t;

	// One enable bit per byte lane of a line
	typedef logic [7:0] byte_en_t;

	// Issuer tag, returned unchanged with the result
	typedef logic [3:0] tag_t;

	// ==============================
	// Encodings
	// ==============================

	// Access size, the byte count is 1 << code
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_HALF  = 2'd1,
		SZ_WORD  = 2'd2,
		SZ_DWORD = 2'd3
	} mem_size_t;

	// States of the slot controller
	typedef enum logic [1:0] {
		SLOT_AVAIL  = 2'd0,
		SLOT_ACTIVE = 2'd1,
		SLOT_DELAY  = 2'd2,
		SLOT_DONE   = 2'd3
	} slot_state_t;

	// Line geometry, LINE_BYTES is 1 << LINE_SHIFT
	localparam int LINE_BYTES = 8;
	localparam int LINE_SHIFT = 3;

endpackage

/* src/mem_op_queue.sv */
/*
 * Memory operation queue
 * Circular FIFO of issued operations in front of the slot controller
 */
module mem_op_queue #(
	parameter int QDEPTH = 4
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   op_valid_i,
	input  logic                   op_store_i,
	input  logic                   op_signed_i,
	input  mem_slot_pkg::mem_size_t op_size_i,
	input  mem_slot_pkg::addr_t    op_addr_i,
	input  mem_slot_pkg::line_t    op_wdata_i,
	input  mem_slot_pkg::tag_t     op_tag_i,
	input  logic                   pop_i,
	output logic                   empty_o,
	output logic                   head_store_o,
	output logic                   head_signed_o,
	output mem_slot_pkg::mem_size_t head_size_o,
	output mem_slot_pkg::addr_t    head_addr_o,
	output mem_slot_pkg::line_t    head_wdata_o,
	output mem_slot_pkg::tag_t     head_tag_o
);
	import mem_slot_pkg::*;

	localparam int PTR_W = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
	localparam int CNT_W = $clog2(QDEPTH + 1);

	// Entry storage, one array per field
	logic      store_mem  [QDEPTH];
	logic      signed_mem [QDEPTH];
	mem_size_t size_mem   [QDEPTH];
	addr_t     addr_mem   [QDEPTH];
	line_t     wdata_mem  [QDEPTH];
	tag_t      tag_mem    [QDEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             wr_en;
	logic             rd_en;

	// Pointers wrap at QDEPTH so any depth works, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		ptr_next = (p == PTR_W'(QDEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full    = (count == CNT_W'(QDEPTH));
	assign empty_o = (count == '0);
	assign wr_en   = op_valid_i && !full;
	assign rd_en   = pop_i && !empty_o;

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			store_mem[wr_ptr]  <= op_store_i;
			signed_mem[wr_ptr] <= op_signed_i;
			size_mem[wr_ptr]   <= op_size_i;
			addr_mem[wr_ptr]   <= op_addr_i;
			wdata_mem[wr_ptr]  <= op_wdata_i;
			tag_mem[wr_ptr]    <= op_tag_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= ptr_next(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_next(rd_ptr);
			// Simultaneous push and pop leave the count alone
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// The head entry is read straight out of storage
	assign head_store_o  = store_mem[rd_ptr];
	assign head_signed_o = signed_mem[rd_ptr];
	assign head_size_o   = size_mem[rd_ptr];
	assign head_addr_o   = addr_mem[rd_ptr];
	assign head_wdata_o  = wdata_mem[rd_ptr];
	assign head_tag_o    = tag_mem[rd_ptr];

	// The issuer spends a credit per push, so a push into a full queue
	// means the credit count on the issue side went wrong
	a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
		op_valid_i |-> !full)
		else $error("issue while queue full");

	// The controller only pops on a non-empty queue
	a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
		pop_i |-> !empty_o)
		else $error("pop while queue empty");

endmodule

/* src/mem_slot_ctrl.sv */
/*
 * Memory slot controller
 * Runs one queued operation at a time on the line bus, splits line-crossing
 * accesses, retries a silent bus and reports each result as a single pulse
 */
module mem_slot_ctrl #(
	parameter int RETRY_CYCLES = 64,
	parameter int MAX_RETRIES  = 3
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   q_empty_i,
	input  logic                   q_store_i,
	input  logic                   q_signed_i,
	input  mem_slot_pkg::mem_size_t q_size_i,
	input  mem_slot_pkg::addr_t    q_addr_i,
	input  mem_slot_pkg::line_t    q_wdata_i,
	input  mem_slot_pkg::tag_t     q_tag_i,
	output logic                   q_pop_o,
	output logic                   credit_o,
	input  logic                   crosses_i,
	input  mem_slot_pkg::line_t    load_value_i,
	output logic                   op_store_o,
	output logic                   op_signed_o,
	output mem_slot_pkg::mem_size_t op_size_o,
	output mem_slot_pkg::addr_t    op_addr_o,
	output mem_slot_pkg::line_t    op_wdata_o,
	output logic                   hi_half_o,
	output logic                   capture_lo_o,
	output logic                   capture_hi_o,
	output logic                   bus_req_o,
	output logic                   bus_we_o,
	input  logic                   bus_ack_i,
	output logic                   res_valid_o,
	output mem_slot_pkg::tag_t     res_tag_o,
	output mem_slot_pkg::line_t    res_data_o,
	output logic                   res_err_o
);
	import mem_slot_pkg::*;

	localparam int TO_W = $clog2(RETRY_CYCLES + 1);
	localparam int RT_W = $clog2(MAX_RETRIES + 1);

	slot_state_t     state_q;
	logic            hi_half_q;
	logic            gap_q;
	logic            err_q;
	logic [TO_W-1:0] to_cnt_q;
	logic [RT_W-1:0] retry_q;
	logic            ack_ok;
	logic            timeout;

	// Work register holding the operation in flight
	logic      w_store_q;
	logic      w_signed_q;
	mem_size_t w_size_q;
	addr_t     w_addr_q;
	line_t     w_wdata_q;
	tag_t      w_tag_q;

	// ==============================
	// Handshakes
	// ==============================

	// A free slot takes the head of the queue at once
	assign q_pop_o  = (state_q == SLOT_AVAIL) && !q_empty_i;
	assign credit_o = q_pop_o;

	// Request is held through SLOT_ACTIVE, except for the retry gap
	assign bus_req_o = (state_q == SLOT_ACTIVE) && !gap_q;
	assign bus_we_o  = w_store_q;

	// An ack only counts while a request is actually out
	assign ack_ok       = bus_req_o && bus_ack_i;
	assign capture_lo_o = ack_ok && !hi_half_q;
	assign capture_hi_o = ack_ok && hi_half_q;

	assign timeout = bus_req_o && !bus_ack_i && (to_cnt_q == TO_W'(RETRY_CYCLES - 1));

	// ==============================
	// Slot state machine
	// ==============================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q   <= SLOT_AVAIL;
			hi_half_q <= 1'b0;
			gap_q     <= 1'b0;
			err_q     <= 1'b0;
			to_cnt_q  <= '0;
			retry_q   <= '0;
		end else begin
			case (state_q)
				SLOT_AVAIL: begin
					if (!q_empty_i) begin
						state_q  <= SLOT_ACTIVE;
						err_q    <= 1'b0;
						gap_q    <= 1'b0;
						to_cnt_q <= '0;
						retry_q  <= '0;
					end
				end
				SLOT_ACTIVE: begin
					if (ack_ok) begin
						to_cnt_q <= '0;
						// Low half of a crossing access needs a second bus cycle
						if (crosses_i && !hi_half_q)
							state_q <= SLOT_DELAY;
						else
							state_q <= SLOT_DONE;
					end else if (gap_q) begin
						// Request comes back up after the one-cycle gap
						gap_q <= 1'b0;
					end else if (timeout) begin
						to_cnt_q <= '0;
						if (retry_q == RT_W'(MAX_RETRIES)) begin
							// Out of retries, the high half is never issued
							err_q   <= 1'b1;
							state_q <= SLOT_DONE;
						end else begin
							gap_q   <= 1'b1;
							retry_q <= retry_q + 1'b1;
						end
					end else begin
						to_cnt_q <= to_cnt_q + 1'b1;
					end
				end
				SLOT_DELAY: begin
					// The high half starts with a fresh retry budget
					hi_half_q <= 1'b1;
					to_cnt_q  <= '0;
					retry_q   <= '0;
					state_q   <= SLOT_ACTIVE;
				end
				default: begin
					hi_half_q <= 1'b0;
					state_q   <= SLOT_AVAIL;
				end
			endcase
		end
	end

	// Load the work register when the head is popped
	always_ff @(posedge clk_i) begin
		if (q_pop_o) begin
			w_store_q  <= q_store_i;
			w_signed_q <= q_signed_i;
			w_size_q   <= q_size_i;
			w_addr_q   <= q_addr_i;
			w_wdata_q  <= q_wdata_i;
			w_tag_q    <= q_tag_i;
		end
	end

	assign op_store_o  = w_store_q;
	assign op_signed_o = w_signed_q;
	assign op_size_o   = w_size_q;
	assign op_addr_o   = w_addr_q;
	assign op_wdata_o  = w_wdata_q;
	assign hi_half_o   = hi_half_q;

	// ==============================
	// Result
	// ==============================

	// SLOT_DONE lasts one cycle, so the result is a single pulse
	assign res_valid_o = (state_q == SLOT_DONE);
	assign res_tag_o   = w_tag_q;
	assign res_err_o   = err_q;
	// Stores and failed accesses report zero
	assign res_data_o  = (err_q || w_store_q) ? '0 : load_value_i;

	// Once up, the request only drops on an ack, for a retry gap, or on
	// the final timeout that ends the operation with an error
	a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
		(bus_req_o && !bus_ack_i) |=>
		(bus_req_o || gap_q || (state_q == SLOT_DONE && err_q)))
		else $error("bus request dropped early");

	// The lane logic must agree that a high half exists
	a_hi_crosses: assert property (@(posedge clk_i) disable iff (rst_i)
		hi_half_o |-> crosses_i)
		else $error("high half on a non-crossing access");

endmodule

/* src/mem_lane_align.sv */
/*
 * Lane alignment
 * Places an access on the byte lanes of the low or high line and flags
 * accesses that spill past the end of their line
 */
module mem_lane_align (
	input  mem_slot_pkg::mem_size_t op_size_i,
	input  mem_slot_pkg::addr_t    op_addr_i,
	input  mem_slot_pkg::line_t    op_wdata_i,
	input  logic                   hi_half_i,
	output mem_slot_pkg::addr_t    bus_addr_o,
	output mem_slot_pkg::byte_en_t bus_be_o,
	output mem_slot_pkg::line_t    bus_wdata_o,
	output logic                   crosses_o
);
	import mem_slot_pkg::*;

	logic [LINE_SHIFT-1:0] offset;
	logic [3:0]            nbytes;
	byte_en_t              size_mask;
	logic [15:0]           be_wide;
	logic [6:0]            hi_shift;
	addr_t                 line_addr;

	assign offset = op_addr_i[LINE_SHIFT-1:0];
	assign nbytes = 4'd1 << op_size_i;

	// One enable per byte of the operand, before placement
	always_comb begin
		case (op_size_i)
			SZ_BYTE: size_mask = 8'h01;
			SZ_HALF: size_mask = 8'h03;
			SZ_WORD: size_mask = 8'h0f;
			default: size_mask = 8'hff;
		endcase
	end

	// Upper byte holds the enables that spill into the next line
	assign be_wide = {8'h00, size_mask} << offset;

	// Bit distance that brings the spilled bytes down to lane 0
	assign hi_shift = {4'(LINE_BYTES) - {1'b0, offset}, 3'b000};

	assign line_addr = {op_addr_i[$bits(addr_t)-1:LINE_SHIFT], {LINE_SHIFT{1'b0}}};

	assign crosses_o = ({1'b0, offset} + nbytes) > 4'(LINE_BYTES);

	always_comb begin
		if (hi_half_i) begin
			bus_be_o    = be_wide[15:8];
			bus_addr_o  = line_addr + addr_t'(LINE_BYTES);
			bus_wdata_o = op_wdata_i >> hi_shift;
		end else begin
			bus_be_o    = be_wide[7:0];
			bus_addr_o  = line_addr;
			bus_wdata_o = op_wdata_i << {offset, 3'b000};
		end
	end

endmodule

/* src/mem_load_merge.sv */
/*
 * Load merge
 * Collects the low and high read lines of a load, joins them and
 * sign- or zero-extends the value to the access size
 */
module mem_load_merge (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   capture_lo_i,
	input  logic                   capture_hi_i,
	input  logic                   crosses_i,
	input  mem_slot_pkg::mem_size_t op_size_i,
	input  logic                   op_signed_i,
	input  mem_slot_pkg::addr_t    op_addr_i,
	input  mem_slot_pkg::line_t    bus_rdata_i,
	output mem_slot_pkg::line_t    load_value_o
);
	import mem_slot_pkg::*;

	logic [LINE_SHIFT-1:0] offset;
	logic [6:0]            hi_shift;
	line_t                 lo_q;
	line_t                 hi_q;
	logic                  hi_vld_q;
	line_t                 raw;

	assign offset   = op_addr_i[LINE_SHIFT-1:0];
	assign hi_shift = {4'(LINE_BYTES) - {1'b0, offset}, 3'b000};

	// Low line moves down to bit 0, high line fills in above it
	always_ff @(posedge clk_i) begin
		if (capture_lo_i)
			lo_q <= bus_rdata_i >> {offset, 3'b000};
		if (capture_hi_i)
			hi_q <= bus_rdata_i << hi_shift;
	end

	// Marks that hi_q belongs to the load in progress
	always_ff @(posedge clk_i) begin
		if (rst_i)
			hi_vld_q <= 1'b0;
		else if (capture_lo_i)
			hi_vld_q <= 1'b0;
		else if (capture_hi_i)
			hi_vld_q <= 1'b1;
	end

	assign raw = (crosses_i && hi_vld_q) ? (lo_q | hi_q) : lo_q;

	// Masking and extension in one step
	always_comb begin
		case (op_size_i)
			SZ_BYTE:
				load_value_o = {{56{op_signed_i & raw[7]}}, raw[7:0]};
			SZ_HALF:
				load_value_o = {{48{op_signed_i & raw[15]}}, raw[15:0]};
			SZ_WORD:
				load_value_o = {{32{op_signed_i & raw[31]}}, raw[31:0]};
			default:
				load_value_o = raw;
		endcase
	end

endmodule

/* src/mem_slot_top.sv */
/*
 * Memory slot top level
 * Issue queue, slot controller and the lane and merge datapath
 */
module mem_slot_top #(
	parameter int QDEPTH       = 4,
	parameter int RETRY_CYCLES = 64,
	parameter int MAX_RETRIES  = 3
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   op_valid_i,
	input  logic                   op_store_i,
	input  mem_slot_pkg::mem_size_t op_size_i,
	input  logic                   op_signed_i,
	input  mem_slot_pkg::addr_t    op_addr_i,
	input  mem_slot_pkg::line_t    op_wdata_i,
	input  mem_slot_pkg::tag_t     op_tag_i,
	output logic                   credit_o,
	output logic                   bus_req_o,
	output logic                   bus_we_o,
	output mem_slot_pkg::addr_t    bus_addr_o,
	output mem_slot_pkg::byte_en_t bus_be_o,
	output mem_slot_pkg::line_t    bus_wdata_o,
	input  logic                   bus_ack_i,
	input  mem_slot_pkg::line_t    bus_rdata_i,
	output logic                   res_valid_o,
	output mem_slot_pkg::tag_t     res_tag_o,
	output mem_slot_pkg::line_t    res_data_o,
	output logic                   res_err_o
);
	import mem_slot_pkg::*;

	// Queue head
	logic      q_empty;
	logic      q_pop;
	logic      q_store;
	logic      q_signed;
	mem_size_t q_size;
	addr_t     q_addr;
	line_t     q_wdata;
	tag_t      q_tag;

	// Operation in flight
	logic      w_signed;
	mem_size_t w_size;
	addr_t     w_addr;
	line_t     w_wdata;
	logic      hi_half;
	logic      crosses;
	logic      capture_lo;
	logic      capture_hi;
	line_t     load_value;

	mem_op_queue #(
		.QDEPTH(QDEPTH)
	) u_queue (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.op_valid_i   (op_valid_i),
		.op_store_i   (op_store_i),
		.op_signed_i  (op_signed_i),
		.op_size_i    (op_size_i),
		.op_addr_i    (op_addr_i),
		.op_wdata_i   (op_wdata_i),
		.op_tag_i     (op_tag_i),
		.pop_i        (q_pop),
		.empty_o      (q_empty),
		.head_store_o (q_store),
		.head_signed_o(q_signed),
		.head_size_o  (q_size),
		.head_addr_o  (q_addr),
		.head_wdata_o (q_wdata),
		.head_tag_o   (q_tag)
	);

	// Store direction reaches the bus through bus_we_o
	mem_slot_ctrl #(
		.RETRY_CYCLES(RETRY_CYCLES),
		.MAX_RETRIES (MAX_RETRIES)
	) u_ctrl (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.q_empty_i   (q_empty),
		.q_store_i   (q_store),
		.q_signed_i  (q_signed),
		.q_size_i    (q_size),
		.q_addr_i    (q_addr),
		.q_wdata_i   (q_wdata),
		.q_tag_i     (q_tag),
		.q_pop_o     (q_pop),
		.credit_o    (credit_o),
		.crosses_i   (crosses),
		.load_value_i(load_value),
		.op_store_o  (),
		.op_signed_o (w_signed),
		.op_size_o   (w_size),
		.op_addr_o   (w_addr),
		.op_wdata_o  (w_wdata),
		.hi_half_o   (hi_half),
		.capture_lo_o(capture_lo),
		.capture_hi_o(capture_hi),
		.bus_req_o   (bus_req_o),
		.bus_we_o    (bus_we_o),
		.bus_ack_i   (bus_ack_i),
		.res_valid_o (res_valid_o),
		.res_tag_o   (res_tag_o),
		.res_data_o  (res_data_o),
		.res_err_o   (res_err_o)
	);

	mem_lane_align u_align (
		.op_size_i  (w_size),
		.op_addr_i  (w_addr),
		.op_wdata_i (w_wdata),
		.hi_half_i  (hi_half),
		.bus_addr_o (bus_addr_o),
		.bus_be_o   (bus_be_o),
		.bus_wdata_o(bus_wdata_o),
		.crosses_o  (crosses)
	);

	mem_load_merge u_merge (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.capture_lo_i(capture_lo),
		.capture_hi_i(capture_hi),
		.crosses_i   (crosses),
		.op_size_i   (w_size),
		.op_signed_i (w_signed),
		.op_addr_i   (w_addr),
		.bus_rdata_i (bus_rdata_i),
		.load_value_o(load_value)
	);

endmodule

/* verif/mem_bus_model.sv */
/*
 * Line memory bus model
 * Answers line bus requests one cycle after they rise, can withhold acks,
 * and counts every rising edge of the request as one attempt
 */
module mem_bus_model (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   pre_we_i,
	input  mem_slot_pkg::addr_t    pre_addr_i,
	input  mem_slot_pkg::line_t    pre_data_i,
	input  logic                   noack_i,
	input  logic                   bus_req_i,
	input  logic                   bus_we_i,
	input  mem_slot_pkg::addr_t    bus_addr_i,
	input  mem_slot_pkg::byte_en_t bus_be_i,
	input  mem_slot_pkg::line_t    bus_wdata_i,
	output logic                   bus_ack_o,
	output mem_slot_pkg::line_t    bus_rdata_o,
	output int                     req_count_o
);
	import mem_slot_pkg::*;

	localparam int NLINES = 1 << ($bits(addr_t) - LINE_SHIFT);

	line_t mem [NLINES];
	logic  req_q;

	// Every line gets a distinct value built from its whole index
	function automatic line_t fill_line(input int idx);
		fill_line = {16'(idx) ^ 16'h5a5a, 16'(idx), ~16'(idx), 16'(idx * 3)};
	endfunction

	always @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < NLINES; i++)
				mem[i] <= fill_line(i);
			bus_ack_o   <= 1'b0;
			bus_rdata_o <= '0;
			req_q       <= 1'b0;
			req_count_o <= 0;
		end else begin
			req_q     <= bus_req_i;
			bus_ack_o <= 1'b0;
			// A new attempt starts whenever the request comes up
			if (bus_req_i && !req_q)
				req_count_o <= req_count_o + 1;
			if (pre_we_i) begin
				mem[pre_addr_i[$bits(addr_t)-1:LINE_SHIFT]] <= pre_data_i;
			end else if (bus_req_i && !bus_ack_o && !noack_i) begin
				// The ack pulse follows the cycle in which the request was seen
				bus_ack_o <= 1'b1;
				if (bus_we_i) begin
					for (int b = 0; b < LINE_BYTES; b++)
						if (bus_be_i[b])
							mem[bus_addr_i[$bits(addr_t)-1:LINE_SHIFT]][8*b +: 8] <=
								bus_wdata_i[8*b +: 8];
				end else begin
					bus_rdata_o <= mem[bus_addr_i[$bits(addr_t)-1:LINE_SHIFT]];
				end
			end
		end
	end

endmodule

/* verif/tb_mem_slot.sv */
/*
 * Memory slot testbench
 * Issues operations from the stimulus file under credits and checks each
 * result, its tag and the number of bus request attempts it took
 */
module tb_mem_slot;
	import mem_slot_pkg::*;

	localparam int    QDEPTH       = 4;
	localparam int    RETRY_CYCLES = 16;
	localparam int    MAX_RETRIES  = 2;
	localparam int    MAX_OPS      = 64;
	localparam int    MAX_PRE      = 16;
	localparam int    WAIT_LIMIT   = 400;
	localparam string STIM_FILE    = "verif/mem_slot_stim.txt";

	logic      clk;
	logic      rst;
	logic      op_valid;
	logic      op_store;
	mem_size_t op_size;
	logic      op_signed;
	addr_t     op_addr;
	line_t     op_wdata;
	tag_t      op_tag;
	logic      credit;
	logic      bus_req;
	logic      bus_we;
	addr_t     bus_addr;
	byte_en_t  bus_be;
	line_t     bus_wdata;
	logic      bus_ack;
	line_t     bus_rdata;
	logic      res_valid;
	tag_t      res_tag;
	line_t     res_data;
	logic      res_err;
	logic      pre_we;
	addr_t     pre_addr;
	line_t     pre_data;
	logic      noack;
	int        req_count;

	// One table entry per P or O line of the stimulus file
	addr_t      pre_addr_a [MAX_PRE];
	line_t      pre_data_a [MAX_PRE];
	logic       st_a       [MAX_OPS];
	logic [1:0] sz_a       [MAX_OPS];
	logic       sg_a       [MAX_OPS];
	addr_t      addr_a     [MAX_OPS];
	line_t      wdata_a    [MAX_OPS];
	tag_t       tag_a      [MAX_OPS];
	line_t      exp_a      [MAX_OPS];
	logic       err_a      [MAX_OPS];
	logic       na_a       [MAX_OPS];
	int         n_pre;
	int         n_ops;

	int   credits;
	logic credit_seen;
	int   seed;

	mem_slot_top #(
		.QDEPTH      (QDEPTH),
		.RETRY_CYCLES(RETRY_CYCLES),
		.MAX_RETRIES (MAX_RETRIES)
	) u_mem_slot_top (
		.clk_i      (clk),
		.rst_i      (rst),
		.op_valid_i (op_valid),
		.op_store_i (op_store),
		.op_size_i  (op_size),
		.op_signed_i(op_signed),
		.op_addr_i  (op_addr),
		.op_wdata_i (op_wdata),
		.op_tag_i   (op_tag),
		.credit_o   (credit),
		.bus_req_o  (bus_req),
		.bus_we_o   (bus_we),
		.bus_addr_o (bus_addr),
		.bus_be_o   (bus_be),
		.bus_wdata_o(bus_wdata),
		.bus_ack_i  (bus_ack),
		.bus_rdata_i(bus_rdata),
		.res_valid_o(res_valid),
		.res_tag_o  (res_tag),
		.res_data_o (res_data),
		.res_err_o  (res_err)
	);

	mem_bus_model u_bus_model (
		.clk_i      (clk),
		.rst_i      (rst),
		.pre_we_i   (pre_we),
		.pre_addr_i (pre_addr),
		.pre_data_i (pre_data),
		.noack_i    (noack),
		.bus_req_i  (bus_req),
		.bus_we_i   (bus_we),
		.bus_addr_i (bus_addr),
		.bus_be_i   (bus_be),
		.bus_wdata_i(bus_wdata),
		.bus_ack_o  (bus_ack),
		.bus_rdata_o(bus_rdata),
		.req_count_o(req_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==============================
	// Error reporting
	// ==============================

	task automatic stop_on_error();
		$display("*** FAILED ***");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string name, input line_t exp, input line_t act);
		$display("MISMATCH %s expected %h actual %h", name, exp, act);
		stop_on_error();
	endtask

	task automatic report_failure(input string what);
		$display("ERROR %s", what);
		stop_on_error();
	endtask

	// ==============================
	// Stimulus and reference rules
	// ==============================

	task automatic read_stim();
		int         fd;
		int         code;
		string      text;
		byte        c;
		logic       f_st;
		logic [1:0] f_sz;
		logic       f_sg;
		addr_t      f_addr;
		line_t      f_wdata;
		tag_t       f_tag;
		line_t      f_exp;
		logic       f_err;
		logic       f_na;
		fd = $fopen(STIM_FILE, "r");
		assert (fd != 0) else report_failure("cannot open the stimulus file");
		n_pre = 0;
		n_ops = 0;
		while ($fgets(text, fd) != 0) begin
			c = text.getc(0);
			if (c == "P") begin
				code = $sscanf(text, "P %h %h", f_addr, f_wdata);
				assert (code == 2 && n_pre < MAX_PRE)
					else report_failure("bad or surplus preload line in the stimulus file");
				pre_addr_a[n_pre] = f_addr;
				pre_data_a[n_pre] = f_wdata;
				n_pre++;
			end else if (c == "O") begin
				code = $sscanf(text, "O %h %h %h %h %h %h %h %h %h", f_st, f_sz, f_sg,
					f_addr, f_wdata, f_tag, f_exp, f_err, f_na);
				assert (code == 9 && n_ops < MAX_OPS)
					else report_failure("bad or surplus operation line in the stimulus file");
				st_a[n_ops]    = f_st;
				sz_a[n_ops]    = f_sz;
				sg_a[n_ops]    = f_sg;
				addr_a[n_ops]  = f_addr;
				wdata_a[n_ops] = f_wdata;
				tag_a[n_ops]   = f_tag;
				exp_a[n_ops]   = f_exp;
				err_a[n_ops]   = f_err;
				na_a[n_ops]    = f_na;
				n_ops++;
			end
		end
		$fclose(fd);
	endtask

	// A silent bus sees the first try plus every retry. Otherwise an access
	// that runs past byte 7 of its line takes two bus cycles
	function automatic int expected_attempts(input logic [1:0] sz, input addr_t addr,
		input logic na);
		int span;
		span = int'(addr[2:0]) + (1 << sz);
		if (na)
			return MAX_RETRIES + 1;
		else if (span > 8)
			return 2;
		else
			return 1;
	endfunction

	// ==============================
	// Drive and check helpers
	// ==============================

	// No credit, request or result may appear without an issued operation
	task automatic check_quiet(input string when);
		assert (credit === 1'b0)
			else report_mismatch({when, " credit_o"}, 64'd0, 64'(credit));
		assert (bus_req === 1'b0)
			else report_mismatch({when, " bus_req_o"}, 64'd0, 64'(bus_req));
		assert (res_valid === 1'b0)
			else report_mismatch({when, " res_valid_o"}, 64'd0, 64'(res_valid));
	endtask

	// Each issue cycle samples 1 unit after the edge and drives 2 units after it.
	// A credit seen in one cycle can be spent from the next one on
	task automatic advance();
		@(posedge clk);
		#1;
		if (credit_seen)
			credits++;
		credit_seen = credit;
		assert (credits <= QDEPTH)
			else report_failure("more credits came back than were spent");
		#1;
		op_valid = 1'b0;
	endtask

	task automatic issue_ops();
		int gap;
		int waited;
		for (int i = 0; i < n_ops; i++) begin
			// The first QDEPTH operations go out back to back
			gap = (i < QDEPTH) ? 0 : ($random(seed) & 3);
			repeat (gap) advance();
			advance();
			waited = 0;
			while (credits == 0) begin
				waited++;
				if (waited > WAIT_LIMIT)
					report_failure($sformatf("no credit came back to issue op %0d", i));
				advance();
			end
			op_valid  = 1'b1;
			op_store  = st_a[i];
			op_size   = mem_size_t'(sz_a[i]);
			op_signed = sg_a[i];
			op_addr   = addr_a[i];
			op_wdata  = wdata_a[i];
			op_tag    = tag_a[i];
			credits--;
		end
		advance();
		waited = 0;
		while (credits != QDEPTH) begin
			waited++;
			if (waited > WAIT_LIMIT)
				report_failure("credits did not all come back after the last issue");
			advance();
		end
	endtask

	task automatic check_results();
		int waited;
		int prev_count;
		int attempts;
		prev_count = 0;
		for (int k = 0; k < n_ops; k++) begin
			// Only the oldest outstanding operation can be on the bus
			noack  = na_a[k];
			waited = 0;
			@(posedge clk);
			#1;
			while (!res_valid) begin
				waited++;
				if (waited > WAIT_LIMIT)
					report_failure($sformatf("no result for op %0d in time", k));
				@(posedge clk);
				#1;
			end
			assert (res_tag === tag_a[k])
				else report_mismatch($sformatf("op%0d tag", k), 64'(tag_a[k]), 64'(res_tag));
			assert (res_err === err_a[k])
				else report_mismatch($sformatf("op%0d err", k), 64'(err_a[k]), 64'(res_err));
			assert (res_data === exp_a[k])
				else report_mismatch($sformatf("op%0d data", k), exp_a[k], res_data);
			attempts   = req_count - prev_count;
			prev_count = req_count;
			assert (attempts == expected_attempts(sz_a[k], addr_a[k], na_a[k]))
				else report_mismatch($sformatf("op%0d attempts", k),
					64'(expected_attempts(sz_a[k], addr_a[k], na_a[k])), 64'(attempts));
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		rst         = 1'b1;
		op_valid    = 1'b0;
		op_store    = 1'b0;
		op_size     = SZ_BYTE;
		op_signed   = 1'b0;
		op_addr     = '0;
		op_wdata    = '0;
		op_tag      = '0;
		pre_we      = 1'b0;
		pre_addr    = '0;
		pre_data    = '0;
		noack       = 1'b0;
		credits     = QDEPTH;
		credit_seen = 1'b0;
		seed        = 32'h674cf33f;
		read_stim();
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		// Preload the model while the slot must stay quiet
		for (int p = 0; p < n_pre; p++) begin
			@(posedge clk);
			#1;
			check_quiet("after reset");
			#1;
			pre_we   = 1'b1;
			pre_addr = pre_addr_a[p];
			pre_data = pre_data_a[p];
		end
		repeat (3) begin
			@(posedge clk);
			#1;
			check_quiet("after reset");
			#1;
			pre_we = 1'b0;
		end
		fork
			issue_ops();
			check_results();
		join
		repeat (4) begin
			@(posedge clk);
			#1;
			check_quiet("after last result");
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* verif/mem_slot_stim.txt */
# P <line address> <line data> preloads one 8-byte line of the bus model
# O <store> <size> <signed> <addr> <wdata> <tag> <exp data> <exp err> <noack>
P 0100 8877665544332211
P 0108 f0e0d0c0b0a09080
P 0110 0123456789abcdef
P 0200 0000000000000000
P 0208 0000000000000000
P 0300 ffeeddccbbaa9988
P 0308 7766554433221100
O 0 0 0 0107 0000000000000000 1 0000000000000088 0 0
O 0 0 1 0107 0000000000000000 2 ffffffffffffff88 0 0
O 0 1 1 010e 0000000000000000 3 fffffffffffff0e0 0 0
O 0 2 0 0104 0000000000000000 4 0000000088776655 0 0
O 0 2 1 0104 0000000000000000 5 ffffffff88776655 0 0
O 0 3 0 0110 0000000000000000 6 0123456789abcdef 0 0
O 0 1 0 0102 0000000000000000 7 0000000000004433 0 0
O 0 1 1 0100 0000000000000000 8 0000000000002211 0 0
O 1 2 0 0204 00000000deadbeef 9 0000000000000000 0 0
O 0 2 0 0204 0000000000000000 a 00000000deadbeef 0 0
O 0 0 0 0203 0000000000000000 b 0000000000000000 0 0
O 0 0 0 0208 0000000000000000 c 0000000000000000 0 0
O 1 3 0 0206 1122334455667788 d 0000000000000000 0 0
O 0 3 0 0206 0000000000000000 e 1122334455667788 0 0
O 0 2 0 0204 0000000000000000 f 000000007788beef 0 0
O 0 0 0 020e 0000000000000000 0 0000000000000000 0 0
O 1 0 0 0201 000000000000005a 8 0000000000000000 0 0
O 0 1 0 0200 0000000000000000 9 0000000000005a00 0 0
O 0 2 1 010e 0000000000000000 1 ffffffffcdeff0e0 0 0
O 0 3 0 0300 0000000000000000 2 0000000000000000 1 1
O 0 1 1 0307 0000000000000000 3 00000000000000ff 0 0
O 1 2 0 030e 00000000cafef00d 4 0000000000000000 1 1
O 0 3 0 0308 0000000000000000 5 7766554433221100 0 0
O 0 0 1 0302 0000000000000000 6 ffffffffffffffaa 0 0
O 0 1 0 0304 0000000000000000 7 000000000000ddcc 0 0

/* verilog.f */
src/mem_slot_pkg.sv
src/mem_op_queue.sv
src/mem_slot_ctrl.sv
src/mem_lane_align.sv
src/mem_load_merge.sv
src/mem_slot_top.sv
verif/mem_bus_model.sv
verif/tb_mem_slot.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory slot testbench with Verilator, run it, and decide the
# outcome from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
	--top-module tb_mem_slot -Mdir "$BUILD_DIR" -o Vtb_mem_slot -f verilog.f; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_mem_slot" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
	echo "simulation passed"
	exit 0
fi

echo "pass message not found in $LOG"
exit 1
